// ==== disp_pkg.sv ====
package disp_pkg;

    localparam int X_BITS = 11;   // horizontal active coordinate
    localparam int Y_BITS = 10;   // vertical active coordinate

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // 24-bit timing bundle from the raster generator
    typedef struct packed {
        logic              vs;
        logic              hs;
        logic              de;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } disp_timing_t;

    // 50-bit display word towards the hdmi transmitter
    typedef struct packed {
        logic              vs;
        logic              hs;
        logic              de;
        logic              href;
        logic              sof;
        rgb888_t           rgb;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
    } disp_pack_t;

    function automatic rgb888_t expand_565(input rgb565_t pix);
        rgb888_t c;
        c.r = {pix.r, 3'b000};   // msb aligned with zero fill
        c.g = {pix.g, 2'b00};
        c.b = {pix.b, 3'b000};
        return c;
    endfunction

endpackage : disp_pkg

// ==== sync_vg.sv ====
module sync_vg #(
    parameter int H_FP   = 300,
    parameter int H_BP   = 300,
    parameter int H_SYNC = 12,
    parameter int H_ACT  = 1280,
    parameter int V_FP   = 9,
    parameter int V_BP   = 9,
    parameter int V_SYNC = 2,
    parameter int V_ACT  = 720
) (
    input  logic                   clk,
    input  logic                   rstn,
    output disp_pkg::disp_timing_t o_timing
);

    import disp_pkg::*;

    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;

    // line order is sync, back porch, active, front porch
    localparam logic [X_BITS-1:0] H_LAST     = X_BITS'(H_TOTAL - 1);
    localparam logic [X_BITS-1:0] H_SYNC_END = X_BITS'(H_SYNC);
    localparam logic [X_BITS-1:0] H_ACT_BEG  = X_BITS'(H_SYNC + H_BP);
    localparam logic [X_BITS-1:0] H_ACT_END  = X_BITS'(H_SYNC + H_BP + H_ACT);
    localparam logic [X_BITS-1:0] H_ACT_W    = X_BITS'(H_ACT);

    // frame uses the same order in lines
    localparam logic [Y_BITS-1:0] V_LAST     = Y_BITS'(V_TOTAL - 1);
    localparam logic [Y_BITS-1:0] V_SYNC_END = Y_BITS'(V_SYNC);
    localparam logic [Y_BITS-1:0] V_ACT_BEG  = Y_BITS'(V_SYNC + V_BP);
    localparam logic [Y_BITS-1:0] V_ACT_END  = Y_BITS'(V_SYNC + V_BP + V_ACT);
    localparam logic [Y_BITS-1:0] V_ACT_W    = Y_BITS'(V_ACT);

    logic [X_BITS-1:0] h_cnt;
    logic [Y_BITS-1:0] v_cnt;
    logic              h_wrap;
    logic              h_in_act;
    logic              v_in_act;
    disp_timing_t      timing_d;
    disp_timing_t      timing_q;

    assign h_wrap = (h_cnt == H_LAST);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;   // end of frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign h_in_act = (h_cnt >= H_ACT_BEG) && (h_cnt < H_ACT_END);
    assign v_in_act = (v_cnt >= V_ACT_BEG) && (v_cnt < V_ACT_END);

    always_comb begin
        timing_d.vs = (v_cnt < V_SYNC_END);
        timing_d.hs = (h_cnt < H_SYNC_END);
        timing_d.de = h_in_act && v_in_act;
        if (timing_d.de) begin
            timing_d.x = h_cnt - H_ACT_BEG;
            timing_d.y = v_cnt - V_ACT_BEG;
        end else begin
            timing_d.x = '0;   // coordinates parked in blanking
            timing_d.y = '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            timing_q <= '0;
        end else begin
            timing_q <= timing_d;
        end
    end

    assign o_timing = timing_q;

    a_coord_in_window: assert property (
        @(posedge clk) disable iff (!rstn)
        timing_q.de |-> (timing_q.x < H_ACT_W) && (timing_q.y < V_ACT_W)
    ) else $error("sync_vg: active coordinate outside window");

    a_no_hs_in_active: assert property (
        @(posedge clk) disable iff (!rstn)
        timing_q.de |-> !timing_q.hs
    ) else $error("sync_vg: hsync overlaps active video");

endmodule : sync_vg

// ==== hdmi_pack.sv ====
module hdmi_pack (
    input  logic                   clk,
    input  logic                   rstn,
    input  disp_pkg::disp_timing_t i_timing,
    input  disp_pkg::rgb565_t      i_pixel,
    input  logic                   i_href,
    output disp_pkg::disp_pack_t   o_pack
);

    import disp_pkg::*;

    logic       at_origin;
    disp_pack_t pack_d;
    disp_pack_t pack_q;

    assign at_origin = (i_timing.x == '0) && (i_timing.y == '0);

    always_comb begin
        pack_d.vs   = i_timing.vs;
        pack_d.hs   = i_timing.hs;
        pack_d.de   = i_timing.de;
        pack_d.href = i_href;                      // camera href left unaligned
        pack_d.sof  = i_timing.de && at_origin;    // first active pixel
        pack_d.rgb  = expand_565(i_pixel);
        pack_d.x    = i_timing.x;
        pack_d.y    = i_timing.y;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pack_q <= '0;
        end else begin
            pack_q <= pack_d;
        end
    end

    assign o_pack = pack_q;

    // start of frame lies in active video, past both sync pulses
    a_sof_in_active: assert property (
        @(posedge clk) disable iff (!rstn)
        pack_q.sof |-> pack_q.de && !pack_q.vs && !pack_q.hs
    ) else $error("hdmi_pack: sof outside active video");

    // one sof per frame, so never on back to back cycles
    a_sof_single: assert property (
        @(posedge clk) disable iff (!rstn)
        pack_q.sof |=> !pack_q.sof
    ) else $error("hdmi_pack: repeated sof");

endmodule : hdmi_pack

// ==== hdmi_display.sv ====
module hdmi_display #(
    parameter int H_FP       = 300,
    parameter int H_BP       = 300,
    parameter int H_SYNC     = 12,
    parameter int H_ACT      = 1280,
    parameter int V_FP       = 9,
    parameter int V_BP       = 9,
    parameter int V_SYNC     = 2,
    parameter int V_ACT      = 720,
    parameter int DATA_DELAY = 25
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_vsync,
    input  logic                 i_href,
    input  disp_pkg::rgb565_t    i_data,
    output disp_pkg::disp_pack_t o_pack
);

    import disp_pkg::*;

    logic         vsync_q;
    logic         lock;
    logic         vg_rstn;
    disp_timing_t timing;
    rgb565_t      pix_dly [DATA_DELAY];
    rgb565_t      pix_aligned;

    // lock on the first vsync rising edge and stay free running
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q <= 1'b0;
            lock    <= 1'b0;
        end else begin
            vsync_q <= i_vsync;
            if (!lock && i_vsync && !vsync_q) begin
                lock <= 1'b1;
            end
        end
    end

    assign vg_rstn = rstn & lock;   // timing generator held until lock

    sync_vg #(
        .H_FP   (H_FP),
        .H_BP   (H_BP),
        .H_SYNC (H_SYNC),
        .H_ACT  (H_ACT),
        .V_FP   (V_FP),
        .V_BP   (V_BP),
        .V_SYNC (V_SYNC),
        .V_ACT  (V_ACT)
    ) u_sync_vg (
        .clk      (clk),
        .rstn     (vg_rstn),
        .o_timing (timing)
    );

    // camera pixels trail the generated raster by DATA_DELAY cycles
    always_ff @(posedge clk) begin
        pix_dly[0] <= i_data;
        for (int i = 1; i < DATA_DELAY; i++) begin
            pix_dly[i] <= pix_dly[i-1];
        end
    end

    assign pix_aligned = pix_dly[DATA_DELAY-1];

    hdmi_pack u_hdmi_pack (
        .clk      (clk),
        .rstn     (rstn),
        .i_timing (timing),
        .i_pixel  (pix_aligned),
        .i_href   (i_href),
        .o_pack   (o_pack)
    );

    a_lock_sticky: assert property (
        @(posedge clk) disable iff (!rstn)
        lock |=> lock
    ) else $error("hdmi_display: lock dropped without reset");

endmodule : hdmi_display

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rstn
);

    timeunit 1ns;
    timeprecision 100ps;

    logic clk_q  = 1'b0;
    logic rstn_q = 1'b0;
    int   edges  = 0;

    always #(PERIOD_NS / 2) clk_q = ~clk_q;

    // release on the clock edge after RESET_CYCLES edges in reset
    always @(posedge clk_q) begin
        if (edges < RESET_CYCLES) begin
            edges <= edges + 1;
        end
        rstn_q <= (edges >= RESET_CYCLES - 1);
    end

    assign o_clk  = clk_q;
    assign o_rstn = rstn_q;

endmodule : tb_clock_gen

// ==== tb_checker.sv ====
module tb_checker #(
    parameter int H_FP       = 3,
    parameter int H_BP       = 3,
    parameter int H_SYNC     = 2,
    parameter int H_ACT      = 16,
    parameter int V_FP       = 1,
    parameter int V_BP       = 1,
    parameter int V_SYNC     = 1,
    parameter int V_ACT      = 6,
    parameter int DATA_DELAY = 25,
    parameter int FRAMES     = 3
) (
    input  logic                 i_clk,
    input  logic                 i_rstn,
    input  logic                 i_vsync,
    input  logic                 i_href,
    input  disp_pkg::rgb565_t    i_data,
    input  disp_pkg::disp_pack_t i_pack,
    output logic                 o_done,
    output logic                 o_locked,
    output int                   o_errors,
    output int                   o_checks
);

    timeunit 1ns;
    timeprecision 100ps;

    import disp_pkg::*;

    localparam int H_TOTAL    = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL    = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int H_OFS      = H_SYNC + H_BP;
    localparam int V_OFS      = V_SYNC + V_BP;
    localparam int RUN_CYCLES = FRAMES * H_TOTAL * V_TOTAL + 3;   // frames plus pipeline

    logic         m_vsync_q = 1'b0;
    logic         m_lock    = 1'b0;
    int           m_h       = 0;
    int           m_v       = 0;
    disp_timing_t m_tq      = '0;   // raster output register
    disp_timing_t m_pt      = '0;   // timing held in the pack register
    logic         m_href    = 1'b0;
    rgb565_t      hist [DATA_DELAY+1];
    int           fill      = 0;
    int           post_lock = 0;
    int           sof_seen  = 0;
    int           errors    = 0;
    int           checks    = 0;
    logic         done      = 1'b0;

    // expected timing for one raster position
    function automatic disp_timing_t raster_at(input int h, input int v);
        disp_timing_t t;
        t.vs = (v < V_SYNC);
        t.hs = (h < H_SYNC);
        t.de = (h >= H_OFS) && (h < H_OFS + H_ACT) && (v >= V_OFS) && (v < V_OFS + V_ACT);
        t.x  = t.de ? X_BITS'(h - H_OFS) : '0;
        t.y  = t.de ? Y_BITS'(v - V_OFS) : '0;
        return t;
    endfunction

    // each channel scaled up to the top of its byte
    function automatic rgb888_t widen_rgb(input rgb565_t p);
        rgb888_t c;
        c.r = p.r * 8'd8;
        c.g = p.g * 8'd4;
        c.b = p.b * 8'd8;
        return c;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("FAIL at %0t ns: %s", $time, msg);
    endtask

    // sampled at the falling edge away from the driving edge
    always @(negedge i_clk) begin
        rgb888_t exp_rgb;
        logic    exp_sof;
        if (!i_rstn) begin
            m_vsync_q = 1'b0;
            m_lock    = 1'b0;
            m_h       = 0;
            m_v       = 0;
            m_tq      = '0;
            m_pt      = '0;
            m_href    = 1'b0;
        end else if (!done) begin
            checks++;
            exp_sof = m_pt.de && (m_pt.x == '0) && (m_pt.y == '0);
            if (i_pack.vs !== m_pt.vs || i_pack.hs !== m_pt.hs || i_pack.de !== m_pt.de) begin
                flag_error($sformatf("vs/hs/de is %b%b%b, expected %b%b%b",
                    i_pack.vs, i_pack.hs, i_pack.de, m_pt.vs, m_pt.hs, m_pt.de));
            end
            if (i_pack.x !== m_pt.x || i_pack.y !== m_pt.y) begin
                flag_error($sformatf("coordinate is (%0d,%0d), expected (%0d,%0d)",
                    i_pack.x, i_pack.y, m_pt.x, m_pt.y));
            end
            if (i_pack.sof !== exp_sof) begin
                flag_error($sformatf("sof is %b, expected %b", i_pack.sof, exp_sof));
            end
            if (i_pack.href !== m_href) begin
                flag_error($sformatf("href is %b, expected %b", i_pack.href, m_href));
            end
            if (m_pt.de && fill > DATA_DELAY) begin
                exp_rgb = widen_rgb(hist[DATA_DELAY]);
                if (i_pack.rgb !== exp_rgb) begin
                    flag_error($sformatf("rgb is %06h, expected %06h", i_pack.rgb, exp_rgb));
                end
            end
            if (i_pack.sof === 1'b1) begin
                sof_seen++;
            end

            // model state for the coming rising edge
            m_pt   = m_tq;
            m_href = i_href;
            if (m_lock) begin
                m_tq = raster_at(m_h, m_v);
                if (m_h == H_TOTAL - 1) begin
                    m_h = 0;
                    m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
                end else begin
                    m_h = m_h + 1;
                end
            end else begin
                m_tq = '0;   // raster held in reset
                m_h  = 0;
                m_v  = 0;
            end
            if (!m_lock && i_vsync && !m_vsync_q) begin
                m_lock = 1'b1;   // first rising vsync only
            end
            m_vsync_q = i_vsync;

            if (m_lock) begin
                post_lock++;
            end
            if (post_lock >= RUN_CYCLES) begin
                if (sof_seen != FRAMES) begin
                    flag_error($sformatf("saw %0d start-of-frame pulses, expected %0d",
                        sof_seen, FRAMES));
                end
                done = 1'b1;
            end
        end

        // pixel history runs through reset like the delay line
        for (int i = DATA_DELAY; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = i_data;
        if (fill <= DATA_DELAY) begin
            fill++;
        end
    end

    assign o_done   = done;
    assign o_locked = m_lock;
    assign o_errors = errors;
    assign o_checks = checks;

endmodule : tb_checker

// ==== tb_hdmi_display.sv ====
module tb_hdmi_display;

    timeunit 1ns;
    timeprecision 100ps;

    import disp_pkg::*;

    localparam int H_SYNC       = 2;
    localparam int H_BP         = 3;
    localparam int H_ACT        = 16;
    localparam int H_FP         = 3;
    localparam int V_SYNC       = 1;
    localparam int V_BP         = 1;
    localparam int V_ACT        = 6;
    localparam int V_FP         = 1;
    localparam int DATA_DELAY   = 25;
    localparam int RESET_CYCLES = 8;
    localparam int VSYNC_HOLD   = 30;   // vsync quiet after reset
    localparam int VSYNC_STEP   = 16;
    localparam int FRAMES       = 3;
    localparam int FRAME_CYCLES = (H_SYNC + H_BP + H_ACT + H_FP) * (V_SYNC + V_BP + V_ACT + V_FP);
    localparam int TIMEOUT      = RESET_CYCLES + VSYNC_HOLD + FRAMES * FRAME_CYCLES + 100;

    logic        clk;
    logic        rstn;
    logic        vsync     = 1'b0;
    logic        href      = 1'b0;
    rgb565_t     data      = '0;
    disp_pack_t  pack;
    logic [15:0] lfsr      = 16'd51;
    int          stim_cnt  = 0;
    int          cycle_cnt = 0;
    logic        done;
    logic        locked;
    int          errors;
    int          checks;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[14:0], lfsr[0]};   // one step per bit
        end
    endtask

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    hdmi_display #(
        .H_FP (H_FP), .H_BP (H_BP), .H_SYNC (H_SYNC), .H_ACT (H_ACT),
        .V_FP (V_FP), .V_BP (V_BP), .V_SYNC (V_SYNC), .V_ACT (V_ACT),
        .DATA_DELAY (DATA_DELAY)
    ) uut (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (vsync),
        .i_href  (href),
        .i_data  (data),
        .o_pack  (pack)
    );

    tb_checker #(
        .H_FP (H_FP), .H_BP (H_BP), .H_SYNC (H_SYNC), .H_ACT (H_ACT),
        .V_FP (V_FP), .V_BP (V_BP), .V_SYNC (V_SYNC), .V_ACT (V_ACT),
        .DATA_DELAY (DATA_DELAY), .FRAMES (FRAMES)
    ) u_checker (
        .i_clk    (clk),
        .i_rstn   (rstn),
        .i_vsync  (vsync),
        .i_href   (href),
        .i_data   (data),
        .i_pack   (pack),
        .o_done   (done),
        .o_locked (locked),
        .o_errors (errors),
        .o_checks (checks)
    );

    always @(posedge clk) begin
        logic [15:0] bits;
        take_bits(16, bits);
        data <= bits;
        take_bits(1, bits);
        href <= bits[0];
        if (rstn) begin
            stim_cnt <= stim_cnt + 1;
            if (stim_cnt >= VSYNC_HOLD && (stim_cnt - VSYNC_HOLD) % VSYNC_STEP == 0) begin
                take_bits(1, bits);
                vsync <= bits[0];   // later edges must not move the raster
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (done) begin
            $display("checker: %0d cycles checked, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end else if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: the checker did not finish within %0d cycles", TIMEOUT);
            if (!locked) begin
                $display("no rising edge on vsync ever locked the display timing");
            end
            $display("checker: %0d cycles checked, %0d errors", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule : tb_hdmi_display

// ==== build.f ====
disp_pkg.sv
sync_vg.sv
hdmi_pack.sv
hdmi_display.sv
tb_clock_gen.sv
tb_checker.sv
tb_hdmi_display.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_hdmi_display \
    -f build.f \
    -o sim_hdmi_display

./obj_dir/sim_hdmi_display 2>&1 | tee "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
echo "simulation finished without failure"
